// ==== compile.f ====
src/common_pkg.sv
src/ram_single_port.sv
src/icache.sv
src/fetch_stage.sv
src/fetch_top.sv
tests/cbus_mem_model.sv
tests/tb_fetch_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert --top-module tb_fetch_top -f compile.f &&
	./obj_dir/Vtb_fetch_top ||
	{ echo "simulation failed" >&2; exit 1; }

// ==== src/common_pkg.sv ====
package common_pkg;

	// ------------------------------
	// Geometry
	// ------------------------------
	localparam int addr_bits = 64;
	localparam int align_bits = 3;        // Byte offset in a 64-bit word
	localparam int offset_bits = 7;       // 128-byte lines
	localparam int index_bits = 4;
	localparam int num_lines = 16;
	localparam int words_per_line = 16;
	localparam int tag_bits = addr_bits - offset_bits - index_bits; // Bits 63..11

	localparam logic [addr_bits-1:0] reset_pc = 64'h1000;

	// ------------------------------
	// Bus encodings
	// ------------------------------
	typedef enum logic [2:0] {
		MSIZE1 = 3'd0,
		MSIZE2 = 3'd1,
		MSIZE4 = 3'd2,
		MSIZE8 = 3'd3
	} msize_t;

	typedef enum logic [3:0] {
		MLEN1 = 4'd0,                     // Beats minus one
		MLEN2 = 4'd1,
		MLEN4 = 4'd3,
		MLEN8 = 4'd7,
		MLEN16 = 4'd15
	} mlen_t;

	typedef enum logic [1:0] {
		AXI_BURST_FIXED = 2'd0,
		AXI_BURST_INCR = 2'd1
	} axi_burst_t;

	typedef enum logic [1:0] {
		INIT = 2'd0,                      // Tag sweep after reset
		IDLE = 2'd1,
		RESP = 2'd2,
		FETCH = 2'd3                      // Line refill
	} icache_state_t;

	// ------------------------------
	// Bus structs
	// ------------------------------
	typedef struct packed {
		logic valid;
		logic [addr_bits-1:0] addr;
	} ibus_req_t;

	typedef struct packed {
		logic addr_ok;
		logic data_ok;
		logic [31:0] data;
	} ibus_resp_t;

	typedef struct packed {
		logic valid;
		logic is_write;
		msize_t size;
		logic [addr_bits-1:0] addr;
		logic [7:0] strobe;
		logic [63:0] data;
		mlen_t len;
		axi_burst_t burst;
	} cbus_req_t;

	typedef struct packed {
		logic ready;
		logic last;
		logic [63:0] data;
	} cbus_resp_t;

endpackage

// ==== src/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage (
	input logic clk,
	input logic reset,
	output common_pkg::ibus_req_t ireq,
	input common_pkg::ibus_resp_t iresp,
	input logic stall,
	input logic redirect,
	input logic [common_pkg::addr_bits-1:0] redirect_pc,
	output logic inst_valid,
	output logic [31:0] inst,
	output logic [common_pkg::addr_bits-1:0] inst_pc
);
	import common_pkg::*;

	logic [addr_bits-1:0] pc;
	logic redirect_pending;
	logic [addr_bits-1:0] redirect_target;

	logic hold;
	logic outstanding;
	logic done;
	logic take;

	assign hold = inst_valid && stall;              // Output held by decode
	assign ireq.valid = !hold;
	assign ireq.addr = pc;

	assign outstanding = ireq.valid && !iresp.data_ok;
	assign done = ireq.valid && iresp.data_ok;
	assign take = done && !redirect && !redirect_pending;

	// ------------------------------
	// Control
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_pc;
			redirect_pending <= 1'b0;
			inst_valid <= 1'b0;
		end else begin
			inst_valid <= take || (hold && !redirect);

			if (redirect && !outstanding) begin
				pc <= redirect_pc;                      // Address is free to change
			end else if (done && redirect_pending) begin
				pc <= redirect_target;
			end else if (take) begin
				pc <= pc + addr_bits'(4);
			end

			if (redirect && outstanding) begin
				redirect_pending <= 1'b1;
			end else if (done) begin
				redirect_pending <= 1'b0;
			end
		end
	end

	// ------------------------------
	// Payload
	// ------------------------------
	always_ff @(posedge clk) begin
		if (take) begin
			inst <= iresp.data;
			inst_pc <= pc;
		end
		if (redirect) begin
			redirect_target <= redirect_pc;
		end
	end

	// Redirect targets feed pc directly
	assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("fetch_stage: pc %h not word aligned", pc);

endmodule

// ==== src/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic redirect,
	input logic [common_pkg::addr_bits-1:0] redirect_pc,
	output logic inst_valid,
	output logic [31:0] inst,
	output logic [common_pkg::addr_bits-1:0] inst_pc,
	output common_pkg::cbus_req_t creq,
	input common_pkg::cbus_resp_t cresp
);
	import common_pkg::*;

	ibus_req_t ireq;                                // Stage to cache
	ibus_resp_t iresp;

	fetch_stage u_fetch_stage (
		.clk(clk),
		.reset(reset),
		.ireq(ireq),
		.iresp(iresp),
		.stall(stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.inst_valid(inst_valid),
		.inst(inst),
		.inst_pc(inst_pc)
	);

	icache u_icache (
		.clk(clk),
		.reset(reset),
		.ireq(ireq),
		.iresp(iresp),
		.creq(creq),
		.cresp(cresp)
	);

endmodule

// ==== src/icache.sv ====
`timescale 1ns/10ps

module icache (
	input logic clk,
	input logic reset,
	input common_pkg::ibus_req_t ireq,
	output common_pkg::ibus_resp_t iresp,
	output common_pkg::cbus_req_t creq,
	input common_pkg::cbus_resp_t cresp
);
	import common_pkg::*;

	icache_state_t state, state_nxt;
	logic [$clog2(num_lines)-1:0] counter, counter_nxt; // Sweep index or beat number

	logic [index_bits-1:0] req_index;
	logic [tag_bits-1:0] req_tag;
	logic hit;

	logic [index_bits-1:0] tag_addr;
	logic tag_wen;
	logic [tag_bits:0] tag_wdata;                   // {valid, tag}
	logic [tag_bits:0] tag_rdata;

	logic [index_bits+offset_bits-align_bits-1:0] data_addr;
	logic data_wen;
	logic [63:0] data_rdata;

	assign req_index = ireq.addr[offset_bits +: index_bits];
	assign req_tag = ireq.addr[addr_bits-1 -: tag_bits];
	assign hit = tag_rdata[tag_bits] && (tag_rdata[tag_bits-1:0] == req_tag);

	// ------------------------------
	// Controller
	// ------------------------------
	always_comb begin
		state_nxt = state;
		counter_nxt = counter;
		tag_wen = 1'b0;
		data_wen = 1'b0;
		unique case (state)
			INIT: begin
				tag_wen = 1'b1;                         // Clear one entry per cycle
				counter_nxt = counter + 1'b1;
				if (counter == $clog2(num_lines)'(num_lines - 1)) begin
					state_nxt = IDLE;
				end
			end
			IDLE: begin
				if (ireq.valid) begin
					if (hit) begin
						state_nxt = RESP;
					end else begin
						state_nxt = FETCH;
						counter_nxt = '0;
					end
				end
			end
			RESP: begin
				state_nxt = IDLE;
			end
			FETCH: begin
				if (cresp.ready) begin
					data_wen = 1'b1;
					counter_nxt = counter + 1'b1;
					if (cresp.last) begin
						tag_wen = 1'b1;                 // Line complete, mark valid
						state_nxt = IDLE;               // Lookup again, now a hit
					end
				end
			end
			default: begin
				state_nxt = INIT;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= INIT;
			counter <= '0;
		end else begin
			state <= state_nxt;
			counter <= counter_nxt;
		end
	end

	// ------------------------------
	// Storage
	// ------------------------------
	assign tag_addr = (state == INIT) ? counter : req_index;
	assign tag_wdata = (state == INIT) ? '0 : {1'b1, req_tag};

	assign data_addr = (state == FETCH) ?
		{req_index, counter[$clog2(words_per_line)-1:0]} :
		ireq.addr[offset_bits+index_bits-1:align_bits];

	ram_single_port #(
		.addr_width(index_bits),
		.data_width(tag_bits + 1),
		.read_latency(0)
	) tag_ram (
		.clk(clk),
		.addr(tag_addr),
		.wen(tag_wen),
		.wdata(tag_wdata),
		.rdata(tag_rdata)
	);

	ram_single_port #(
		.addr_width(index_bits + offset_bits - align_bits),
		.data_width(64),
		.read_latency(1)
	) data_ram (
		.clk(clk),
		.addr(data_addr),
		.wen(data_wen),
		.wdata(cresp.data),
		.rdata(data_rdata)
	);

	// ------------------------------
	// Bus outputs
	// ------------------------------
	assign iresp.addr_ok = (state == IDLE);
	assign iresp.data_ok = (state == RESP);
	assign iresp.data = ireq.addr[2] ? data_rdata[63:32] : data_rdata[31:0];

	assign creq.valid = (state == FETCH);
	assign creq.is_write = 1'b0;
	assign creq.size = MSIZE8;
	assign creq.addr = {ireq.addr[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
	assign creq.strobe = '0;
	assign creq.data = '0;
	assign creq.len = MLEN16;
	assign creq.burst = AXI_BURST_INCR;

	// Refill address comes straight from the request
	assert property (@(posedge clk) disable iff (reset)
		state == FETCH |-> $stable(ireq.addr))
		else $error("icache: ireq.addr changed during refill");

	// An answer belongs to a request that still hits
	assert property (@(posedge clk) disable iff (reset)
		iresp.data_ok |-> ireq.valid && hit)
		else $error("icache: data_ok without a hitting request");

	// First lookup after the sweep sees an invalid entry
	assert property (@(posedge clk) disable iff (reset)
		state == IDLE && $past(state) == INIT |-> !tag_rdata[tag_bits])
		else $error("icache: valid tag left after the sweep");

endmodule

// ==== src/ram_single_port.sv ====
`timescale 1ns/10ps

module ram_single_port #(
	parameter int addr_width = 4,
	parameter int data_width = 64,
	parameter int read_latency = 0
) (
	input logic clk,
	input logic [addr_width-1:0] addr,
	input logic wen,
	input logic [data_width-1:0] wdata,
	output logic [data_width-1:0] rdata
);

	logic [data_width-1:0] mem [2**addr_width];

	always_ff @(posedge clk) begin
		if (wen) begin
			mem[addr] <= wdata;
		end
	end

	generate
		if (read_latency == 0) begin : g_async_read
			assign rdata = mem[addr];                   // Distributed style read
		end else begin : g_sync_read
			always_ff @(posedge clk) begin
				rdata <= mem[addr];                     // Block RAM style read
			end
		end
	endgenerate

	// Only the two read paths above exist
	assert property (@(posedge clk) read_latency == 0 || read_latency == 1)
		else $error("ram_single_port: read_latency %0d not supported", read_latency);

endmodule

// ==== tests/cbus_mem_model.sv ====
`timescale 1ns/10ps

module cbus_mem_model (
	input logic clk,
	input common_pkg::cbus_req_t creq,
	output common_pkg::cbus_resp_t cresp,
	output logic [common_pkg::addr_bits-1:0] beat_addr,
	input logic [63:0] beat_data,
	output logic req_error
);
	import common_pkg::*;

	logic active = 1'b0;                            // Burst in progress
	logic ready = 1'b0;
	logic last = 1'b0;
	logic [3:0] beat = 4'd0;
	logic [addr_bits-1:0] line_addr = '0;
	logic bad = 1'b0;

	assign beat_addr = {line_addr[addr_bits-1:offset_bits], beat, 3'b000};
	assign cresp = {ready, last, beat_data};        // Data follows the beat address
	assign req_error = bad;

	task automatic flag_request(input string what);
		$display("cbus request check failed at %0t ns: %s", $time, what);
		bad = 1'b1;
	endtask

	// ------------------------------
	// Check, then answer
	// ------------------------------
	always @(negedge clk) begin
		if (creq.valid) begin
			assert (creq.addr[offset_bits-1:0] == '0 && !creq.is_write && creq.size == MSIZE8
				&& creq.len == MLEN16 && creq.burst == AXI_BURST_INCR
				&& creq.strobe == '0 && creq.data == '0)
				else flag_request("not a line-aligned 16-beat incrementing read");
		end
		if (active && creq.valid) begin
			assert (creq.addr == line_addr)
				else flag_request("address changed during a burst");
		end
		if (active && !(ready && last)) begin
			assert (creq.valid) else flag_request("valid dropped before the last beat");
		end

		if (ready) begin                            // Beat taken at the last rising edge
			beat = beat + 4'd1;
			if (last) begin
				active = 1'b0;
			end
		end
		if (!active && creq.valid) begin
			active = 1'b1;
			beat = 4'd0;
			line_addr = creq.addr;
		end
		ready = active && ($urandom_range(3) != 0); // Gap in about one cycle of four
		last = ready && (beat == 4'd15);
	end

endmodule

// ==== tests/tb_fetch_top.sv ====
`timescale 1ns/10ps

module tb_fetch_top;
	import common_pkg::*;

	logic clk = 1'b0;
	logic reset;
	logic stall;
	logic redirect;
	logic [addr_bits-1:0] redirect_pc;
	logic inst_valid;
	logic [31:0] inst;
	logic [addr_bits-1:0] inst_pc;
	cbus_req_t creq;
	cbus_resp_t cresp;
	logic [addr_bits-1:0] beat_addr;
	logic [63:0] beat_data;
	logic req_error;

	// Input values as seen by the last rising edge
	logic stall_seen;
	logic redirect_seen;
	logic [addr_bits-1:0] redirect_pc_seen;

	int edge_count = 0;
	logic prev_valid = 1'b0;
	logic [31:0] prev_inst = '0;
	logic [addr_bits-1:0] prev_pc = '0;
	logic [addr_bits-1:0] expected_pc = reset_pc;
	logic prev_creq_valid = 1'b0;
	logic refill_open = 1'b0;
	logic [addr_bits-offset_bits-1:0] refill_line = '0;
	logic [num_lines-1:0] line_valid = '0;         // Reference direct-mapped cache
	logic [tag_bits-1:0] line_tag [num_lines];

	fetch_top uut (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.inst_valid(inst_valid),
		.inst(inst),
		.inst_pc(inst_pc),
		.creq(creq),
		.cresp(cresp)
	);

	cbus_mem_model u_mem (
		.clk(clk),
		.creq(creq),
		.cresp(cresp),
		.beat_addr(beat_addr),
		.beat_data(beat_data),
		.req_error(req_error)
	);

	always #5 clk = ~clk;

	function automatic logic [63:0] mem_word(input logic [addr_bits-1:0] addr);
		return ((addr << 29) | (addr >> 3)) ^ 64'h9e37_79b9_c2b2_ae35;
	endfunction

	function automatic logic [31:0] expected_inst(input logic [addr_bits-1:0] pc);
		logic [63:0] word;
		word = mem_word({pc[addr_bits-1:3], 3'b000});
		return pc[2] ? word[63:32] : word[31:0];
	endfunction

	assign beat_data = mem_word(beat_addr);

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("Error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic abort_with(input string what);
		$display("At %0t ns: %s", $time, what);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	always @(posedge req_error) abort_with("memory model rejected a cbus request");

	always @(posedge clk) begin
		stall_seen <= stall;
		redirect_seen <= redirect;
		redirect_pc_seen <= redirect_pc;
	end

	// ------------------------------
	// Monitor
	// ------------------------------
	always @(negedge clk) begin : monitor
		logic [index_bits-1:0] idx;
		logic miss;
		edge_count = edge_count + 1;
		if (edge_count <= 4 + num_lines) begin      // Reset plus tag sweep
			assert (!inst_valid && !creq.valid)
				else abort_with("fetch activity during reset or the tag sweep");
		end
		if (creq.valid && !prev_creq_valid) begin
			refill_line = creq.addr[addr_bits-1:offset_bits];
			refill_open = 1'b1;
		end
		prev_creq_valid = creq.valid;

		if (prev_valid && stall_seen && !redirect_seen) begin
			assert (inst_valid) else abort_with("inst_valid dropped while stalled");
			assert (inst_pc == prev_pc) else report_mismatch("inst_pc", prev_pc, inst_pc);
			assert (inst == prev_inst) else report_mismatch("inst", 64'(prev_inst), 64'(inst));
		end else if (inst_valid) begin
			idx = inst_pc[offset_bits +: index_bits];
			miss = !(line_valid[idx] && line_tag[idx] == inst_pc[addr_bits-1 -: tag_bits]);
			assert (inst_pc == expected_pc) else report_mismatch("inst_pc", expected_pc, inst_pc);
			assert (inst == expected_inst(inst_pc))
				else report_mismatch("inst", 64'(expected_inst(inst_pc)), 64'(inst));
			assert (refill_open == miss)
				else abort_with($sformatf("pc %h: refill expected %0b, seen %0b",
					inst_pc, miss, refill_open));
			if (refill_open) begin
				assert (refill_line == inst_pc[addr_bits-1:offset_bits])
					else report_mismatch("creq.addr", {inst_pc[addr_bits-1:offset_bits], 7'b0},
						{refill_line, 7'b0});
			end
			line_valid[idx] = 1'b1;
			line_tag[idx] = inst_pc[addr_bits-1 -: tag_bits];
			refill_open = 1'b0;
			expected_pc = inst_pc + 64'd4;
		end
		if (redirect_seen) begin
			expected_pc = redirect_pc_seen;
		end
		prev_valid = inst_valid;
		prev_pc = inst_pc;
		prev_inst = inst;
	end

	// ------------------------------
	// Stimulus
	// ------------------------------
	task automatic wait_for_inst(input int max_cycles);
		int n;
		n = 0;
		@(negedge clk);
		while (!inst_valid) begin
			n = n + 1;
			if (n > max_cycles) abort_with("timeout waiting for inst_valid");
			@(negedge clk);
		end
	endtask

	task automatic hold_stall(input int cycles);
		stall = 1'b1;
		repeat (cycles) @(negedge clk);
		stall = 1'b0;
	endtask

	task automatic redirect_while_held(input logic [addr_bits-1:0] target);
		stall = 1'b1;                               // No fetch in flight while held
		@(negedge clk);
		redirect = 1'b1;
		redirect_pc = target;
		@(negedge clk);
		redirect = 1'b0;
		stall = 1'b0;
	endtask

	task automatic redirect_in_flight(input logic [addr_bits-1:0] target);
		redirect = 1'b1;                            // Next fetch is already on the bus
		redirect_pc = target;
		@(negedge clk);
		redirect = 1'b0;
	endtask

	initial begin
		void'($urandom(32'hc99e_2fd0));
		reset = 1'b1;
		stall = 1'b0;
		redirect = 1'b0;
		redirect_pc = '0;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		repeat (70) wait_for_inst(500);             // Crosses two line boundaries
		hold_stall(5);
		repeat (3) wait_for_inst(500);
		redirect_while_held(reset_pc + 64'h40);     // Lines already cached
		repeat (20) wait_for_inst(500);
		redirect_while_held(reset_pc + 64'h800);    // Same index, other tag
		repeat (4) wait_for_inst(500);
		redirect_while_held(reset_pc + 64'h8);
		repeat (4) wait_for_inst(500);
		redirect_in_flight(reset_pc + 64'h100);     // Answer to the pending fetch is dropped
		repeat (4) wait_for_inst(500);
		repeat (2) @(negedge clk);

		$display("=== PASS ===");
		$finish;
	end

endmodule
